//--- tracking_engine.f
hw/te_regmap_pkg.sv
hw/te_core_pkg.sv
hw/te_correlator_lane.sv
hw/te_channel_finder.sv
hw/te_sequencer.sv
hw/te_host_regs.sv
hw/tracking_engine.sv
sim/tracking_engine_asserts.sv
sim/tb_tracking_engine.sv

//--- Bender.yml
package:
  name: tracking_engine

sources:
  - files:
      - hw/te_regmap_pkg.sv
      - hw/te_core_pkg.sv
      - hw/te_correlator_lane.sv
      - hw/te_channel_finder.sv
      - hw/te_sequencer.sv
      - hw/te_host_regs.sv
      - hw/tracking_engine.sv
  - target: simulation
    files:
      - sim/tracking_engine_asserts.sv
      - sim/tb_tracking_engine.sv

//--- sim/tb_tracking_engine.sv
// testbench for the tracking engine: stimulus table, FIFO model, reference model, checks
`timescale 1ns/1ps

module tb_tracking_engine import te_regmap_pkg::*; import te_core_pkg::*; ();

	localparam int NUM_LANES      = 4;
	localparam int NUM_TESTS      = 5;
	localparam int MAX_BLOCK      = 20;
	localparam int TIMEOUT_CYCLES = 2000;

	typedef struct packed {
		te_chan_mask_t                   mask;
		te_code_t                        poly;
		te_code_t [TE_NUM_CHANNELS-1:0]  seeds; // seeds[k] belongs to channel k
		logic [7:0]                      len;   // samples in the block
	} test_entry_t;

	logic         clk;
	logic         rst_b;
	logic         i_start;
	logic         i_fifo_ready;
	logic         i_fifo_last_data;
	logic         i_fifo_data_valid;
	te_sample_t   i_fifo_data;
	logic         i_reg_cs;
	logic         i_rd;
	logic         i_wr;
	te_reg_addr_t i_addr;
	te_word_t     i_wdata;
	logic         o_te_running;
	logic         o_te_ready;
	logic         o_te_over;
	logic         o_fifo_read;
	logic         o_fifo_rewind;
	logic         o_fifo_skip;
	te_word_t     o_reg_rdata;

	test_entry_t  tests [NUM_TESTS];
	te_sample_t   blk [MAX_BLOCK];
	int           blk_len;
	integer       seed;
	te_acc_t      exp_acc [TE_NUM_CHANNELS];
	int           exp_rounds;

	// FIFO model state and strobe counters
	logic         streaming;
	int           pos;
	int           read_cnt;
	int           rewind_cnt;
	int           skip_cnt;
	int           over_cnt;

	always #4 clk = ~clk;

	tracking_engine #(.NUM_LANES(NUM_LANES)) DUT (.*);

	// ------------------------------------------------
	// behavioral FIFO, one sample per cycle after each read pulse
	// ------------------------------------------------
	always @(negedge clk) begin
		if (streaming) begin
			if (pos < blk_len) begin
				i_fifo_data       = blk[pos];
				i_fifo_data_valid = 1'b1;
				i_fifo_last_data  = (pos == blk_len - 1);
				pos++;
			end else begin
				i_fifo_data_valid = 1'b0;
				i_fifo_last_data  = 1'b0;
				streaming         = 1'b0;
			end
		end
		if (o_fifo_read) begin // block starts in the next cycle
			streaming = 1'b1;
			pos       = 0;
			read_cnt++;
		end
		if (o_fifo_rewind)
			rewind_cnt++;
		if (o_fifo_skip)
			skip_cnt++;
		if (o_te_over)
			over_cnt++;
	end

	// ------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string name, input te_word_t got, input te_word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got 0x%h expected 0x%h",
			                            $time, name, got, exp));
	endtask

	task automatic check_acc(input string name, input te_acc_t got, input te_acc_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got %0d expected %0d",
			                            $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
			                            $time, name, got, exp));
	endtask

	// ------------------------------------------------
	// host bus access
	// ------------------------------------------------
	task automatic write_reg(input te_reg_addr_t addr, input te_word_t data);
		@(negedge clk);
		i_reg_cs = 1'b1;
		i_wr     = 1'b1;
		i_addr   = addr;
		i_wdata  = data;
		@(negedge clk);
		i_reg_cs = 1'b0;
		i_wr     = 1'b0;
	endtask

	task automatic read_reg(input te_reg_addr_t addr, output te_word_t data);
		@(negedge clk);
		i_reg_cs = 1'b1;
		i_rd     = 1'b1;
		i_addr   = addr;
		#2 data  = o_reg_rdata; // combinational, settled mid cycle
		@(negedge clk);
		i_reg_cs = 1'b0;
		i_rd     = 1'b0;
	endtask

	// expected sums per channel and the number of rounds
	task automatic run_model(input test_entry_t e);
		te_code_t lfsr;
		te_acc_t  acc;
		int       n;
		n = 0;
		for (int k = 0; k < TE_NUM_CHANNELS; k++) begin
			exp_acc[k] = '0;
			if (e.mask[k]) begin
				n++;
				lfsr = e.seeds[k];
				acc  = '0;
				for (int i = 0; i < blk_len; i++) begin
					if (lfsr[0])
						acc = acc + te_acc_t'(blk[i]);
					else
						acc = acc - te_acc_t'(blk[i]);
					lfsr = lfsr[0] ? ((lfsr >> 1) ^ e.poly) : (lfsr >> 1);
				end
				exp_acc[k] = acc;
			end
		end
		exp_rounds = (n + NUM_LANES - 1) / NUM_LANES;
		if (exp_rounds < 1)
			exp_rounds = 1;
	endtask

	task automatic wait_te_over();
		int cyc;
		cyc = 0;
		while (!o_te_over) begin
			@(negedge clk);
			cyc++;
			if (cyc > TIMEOUT_CYCLES)
				stop_with_failure("timeout: o_te_over never went high after start");
		end
	endtask

	// ------------------------------------------------
	// one table entry: configure, run, compare
	// ------------------------------------------------
	task automatic run_test(input test_entry_t e);
		te_word_t rd;
		te_word_t exp_ext;
		blk_len = e.len;
		for (int i = 0; i < blk_len; i++)
			blk[i] = te_sample_t'($random(seed));
		write_reg(TE_CHANNEL_ENABLE, te_word_t'(e.mask));
		write_reg(TE_POLYNOMIAL, te_word_t'(e.poly));
		for (int k = 0; k < TE_NUM_CHANNELS; k++)
			write_reg(TE_SEED_BASE + k, te_word_t'(e.seeds[k]));
		read_reg(TE_CHANNEL_ENABLE, rd);
		check_word("CHANNEL_ENABLE", rd, te_word_t'(e.mask));
		read_reg(TE_POLYNOMIAL, rd);
		check_word("POLYNOMIAL", rd, te_word_t'(e.poly));
		for (int k = 0; k < TE_NUM_CHANNELS; k++) begin
			read_reg(TE_SEED_BASE + k, rd);
			check_word($sformatf("SEED%0d", k), rd, te_word_t'(e.seeds[k]));
		end
		run_model(e);
		read_cnt   = 0;
		rewind_cnt = 0;
		skip_cnt   = 0;
		over_cnt   = 0;
		@(negedge clk) i_start = 1'b1;
		@(negedge clk) i_start = 1'b0;
		check_bit("o_te_running", o_te_running, 1'b1);
		wait_te_over();
		repeat (3) @(negedge clk);
		check_word("o_fifo_read count", read_cnt, (e.mask == '0) ? 0 : exp_rounds);
		check_word("o_fifo_rewind count", rewind_cnt, (e.mask == '0) ? 0 : exp_rounds - 1);
		check_word("o_fifo_skip count", skip_cnt, 1);
		check_word("o_te_over count", over_cnt, 1);
		check_bit("o_te_running", o_te_running, 1'b0);
		check_bit("o_te_ready", o_te_ready, e.mask != '0);
		read_reg(TE_COH_DATA_READY, rd);
		check_word("COH_DATA_READY", rd, te_word_t'(e.mask));
		read_reg(TE_CURR_STATE, rd);
		check_word("CURR_STATE", rd, te_word_t'(WAIT_CPU));
		for (int k = 0; k < TE_NUM_CHANNELS; k++) begin
			if (e.mask[k]) begin
				read_reg(TE_RESULT_BASE + k, rd);
				exp_ext = {{8{exp_acc[k][23]}}, exp_acc[k]};
				check_acc($sformatf("RESULT%0d", k), te_acc_t'(rd), exp_acc[k]);
				check_word($sformatf("RESULT%0d word", k), rd, exp_ext);
			end
		end
	endtask

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin
		te_word_t rd;
		// mask, polynomial, seeds of channels 7..0, block length
		tests[0] = '{8'h0B, 16'hB400, {16'h1D2F, 16'h0001, 16'hACE1, 16'h7F31,
		                               16'h4C55, 16'h9A0E, 16'h3333, 16'hF00D}, 8'd12};
		tests[1] = '{8'hF6, 16'hA001, {16'h0E1B, 16'h5A5A, 16'hC3C3, 16'h1234,
		                               16'hFEDC, 16'h8001, 16'h6B2D, 16'h0F0F}, 8'd20};
		tests[2] = '{8'hFF, 16'h8016, {16'h2468, 16'h1357, 16'hBEEF, 16'hCAFE,
		                               16'h7777, 16'h0102, 16'hE5E5, 16'h9999}, 8'd3};
		tests[3] = '{8'h14, 16'hD008, {16'h4321, 16'hAAAA, 16'h0F1E, 16'h55AA,
		                               16'h1111, 16'hD00D, 16'h8421, 16'h7E7E}, 8'd9};
		tests[4] = '{8'h00, 16'hB400, {16'h0101, 16'h0202, 16'h0303, 16'h0404,
		                               16'h0505, 16'h0606, 16'h0707, 16'h0808}, 8'd5};
		seed              = 60;
		clk               = 1'b0;
		rst_b             = 1'b0;
		i_start           = 1'b0;
		i_fifo_ready      = 1'b0;
		i_fifo_last_data  = 1'b0;
		i_fifo_data_valid = 1'b0;
		i_fifo_data       = '0;
		i_reg_cs          = 1'b0;
		i_rd              = 1'b0;
		i_wr              = 1'b0;
		i_addr            = '0;
		i_wdata           = '0;
		streaming         = 1'b0;
		pos               = 0;
		blk_len           = 0;
		repeat (2) @(posedge clk);
		@(negedge clk) rst_b = 1'b1;

		// state right after reset
		check_bit("o_te_running", o_te_running, 1'b0);
		check_bit("o_te_over", o_te_over, 1'b0);
		check_bit("o_fifo_read", o_fifo_read, 1'b0);
		check_bit("o_fifo_rewind", o_fifo_rewind, 1'b0);
		check_bit("o_fifo_skip", o_fifo_skip, 1'b0);
		read_reg(TE_CHANNEL_ENABLE, rd);
		check_word("CHANNEL_ENABLE", rd, '0);
		read_reg(TE_COH_DATA_READY, rd);
		check_word("COH_DATA_READY", rd, '0);

		i_fifo_ready = 1'b1; // a block is always on offer
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(tests[t]);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- sim/tracking_engine_asserts.sv
// concurrent checks on the top level finish pulse and FIFO strobes, bound into the DUT
`timescale 1ns/1ps

module tracking_engine_asserts (
	input logic clk,
	input logic rst_b,
	input logic i_te_running,
	input logic i_te_over,
	input logic i_fifo_read,
	input logic i_fifo_rewind,
	input logic i_fifo_skip
);

	// ------------------------------------------------
	// finish pulse
	// ------------------------------------------------
	over_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_b)
		$rose(i_te_over) |=> !i_te_over
	) else $error("o_te_over stayed high for more than one cycle");

	// ------------------------------------------------
	// FIFO strobes
	// ------------------------------------------------
	strobes_exclusive: assert property (
		@(posedge clk) disable iff (!rst_b)
		$onehot0({i_fifo_read, i_fifo_rewind, i_fifo_skip})
	) else $error("more than one FIFO strobe high in the same cycle");

	read_while_running: assert property (
		@(posedge clk) disable iff (!rst_b)
		i_fifo_read |-> i_te_running
	) else $error("o_fifo_read high while the engine is not running");

endmodule

bind tracking_engine tracking_engine_asserts u_asserts (
	.clk           (clk),
	.rst_b         (rst_b),
	.i_te_running  (o_te_running),
	.i_te_over     (o_te_over),
	.i_fifo_read   (o_fifo_read),
	.i_fifo_rewind (o_fifo_rewind),
	.i_fifo_skip   (o_fifo_skip)
);

//--- hw/tracking_engine.sv
// tracking engine top: sequencer, channel finder, correlator lanes, host registers
`timescale 1ns/1ps

module tracking_engine import te_regmap_pkg::*; import te_core_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic          clk,
	input  logic          rst_b,
	// control and status
	input  logic          i_start,
	output logic          o_te_running,
	output logic          o_te_ready,
	output logic          o_te_over,
	// sample FIFO
	input  logic          i_fifo_ready,
	input  logic          i_fifo_last_data,
	input  logic          i_fifo_data_valid,
	input  te_sample_t    i_fifo_data,
	output logic          o_fifo_read,
	output logic          o_fifo_rewind,
	output logic          o_fifo_skip,
	// host register bus
	input  logic          i_reg_cs,
	input  logic          i_rd,
	input  logic          i_wr,
	input  te_reg_addr_t  i_addr,
	input  te_word_t      i_wdata,
	output te_word_t      o_reg_rdata
);

	te_state_e            state;
	logic                 latch_enable;
	logic                 find_start;
	logic                 lane_load;
	logic                 sample_en;
	logic                 dump;
	logic                 any_enabled;
	logic                 find_done;
	logic                 all_done;

	te_chan_mask_t        channel_enable;
	te_code_t             poly;
	te_code_t             seeds [TE_NUM_CHANNELS];

	logic [NUM_LANES-1:0] lane_en;
	te_chan_idx_t         lane_chan [NUM_LANES];
	te_code_t             lane_seed [NUM_LANES];
	te_acc_t              lane_acc [NUM_LANES];

	// ------------------------------------------------
	// round control
	// ------------------------------------------------
	te_sequencer u_sequencer (
		.clk               (clk),
		.rst_b             (rst_b),
		.i_start           (i_start),
		.i_fifo_ready      (i_fifo_ready),
		.i_fifo_last_data  (i_fifo_last_data),
		.i_fifo_data_valid (i_fifo_data_valid),
		.i_any_enabled     (any_enabled),
		.i_find_done       (find_done),
		.i_all_done        (all_done),
		.o_state           (state),
		.o_latch_enable    (latch_enable),
		.o_find_start      (find_start),
		.o_lane_load       (lane_load),
		.o_sample_en       (sample_en),
		.o_dump            (dump),
		.o_te_running      (o_te_running),
		.o_te_over         (o_te_over),
		.o_fifo_read       (o_fifo_read),
		.o_fifo_rewind     (o_fifo_rewind),
		.o_fifo_skip       (o_fifo_skip)
	);

	te_channel_finder #(.NUM_LANES(NUM_LANES)) u_finder (
		.clk              (clk),
		.rst_b            (rst_b),
		.i_latch_enable   (latch_enable),
		.i_find_start     (find_start),
		.i_channel_enable (channel_enable),
		.i_seeds          (seeds),
		.o_find_done      (find_done),
		.o_all_done       (all_done),
		.o_any_enabled    (any_enabled),
		.o_lane_en        (lane_en),
		.o_lane_chan      (lane_chan),
		.o_lane_seed      (lane_seed)
	);

	// ------------------------------------------------
	// correlator lanes, all on the same sample stream
	// ------------------------------------------------
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		te_correlator_lane u_lane (
			.clk         (clk),
			.rst_b       (rst_b),
			.i_load      (lane_load),
			.i_seed      (lane_seed[g]),
			.i_poly      (poly),
			.i_sample_en (sample_en),
			.i_sample    (i_fifo_data),
			.o_acc       (lane_acc[g])
		);
	end

	te_host_regs #(.NUM_LANES(NUM_LANES)) u_regs (
		.clk              (clk),
		.rst_b            (rst_b),
		.i_reg_cs         (i_reg_cs),
		.i_rd             (i_rd),
		.i_wr             (i_wr),
		.i_addr           (i_addr),
		.i_wdata          (i_wdata),
		.i_state          (state),
		.i_latch_enable   (latch_enable),
		.i_dump           (dump),
		.i_lane_en        (lane_en),
		.i_lane_chan      (lane_chan),
		.i_lane_acc       (lane_acc),
		.o_channel_enable (channel_enable),
		.o_poly           (poly),
		.o_seeds          (seeds),
		.o_te_ready       (o_te_ready),
		.o_reg_rdata      (o_reg_rdata)
	);

endmodule

//--- hw/te_host_regs.sv
// host registers: configuration, per channel results, ready bitmap, read mux
`timescale 1ns/1ps

module te_host_regs import te_regmap_pkg::*; import te_core_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_reg_cs,
	input  logic                 i_rd,
	input  logic                 i_wr,
	input  te_reg_addr_t         i_addr,
	input  te_word_t             i_wdata,
	input  te_state_e            i_state,
	input  logic                 i_latch_enable, // new block, clear ready bits
	input  logic                 i_dump,
	input  logic [NUM_LANES-1:0] i_lane_en,
	input  te_chan_idx_t         i_lane_chan [NUM_LANES],
	input  te_acc_t              i_lane_acc [NUM_LANES],
	output te_chan_mask_t        o_channel_enable,
	output te_code_t             o_poly,
	output te_code_t             o_seeds [TE_NUM_CHANNELS],
	output logic                 o_te_ready,
	output te_word_t             o_reg_rdata
);

	localparam int ACC_W = $bits(te_acc_t);
	localparam int PAD_W = $bits(te_word_t) - ACC_W;

	te_acc_t       result_q [TE_NUM_CHANNELS];
	te_chan_mask_t ready_q;
	te_chan_mask_t dump_mask;
	te_chan_idx_t  chan_sel;
	te_acc_t       result_sel;
	logic          wr_en;
	logic          rd_en;
	logic          seed_hit;
	logic          result_hit;

	assign wr_en = i_reg_cs && i_wr;
	assign rd_en = i_reg_cs && i_rd;

	// ------------------------------------------------
	// address decode for the per channel blocks
	// ------------------------------------------------
	assign seed_hit   = (i_addr >= TE_SEED_BASE) &&
	                    (i_addr < TE_SEED_BASE + TE_NUM_CHANNELS);
	assign result_hit = (i_addr >= TE_RESULT_BASE) &&
	                    (i_addr < TE_RESULT_BASE + TE_NUM_CHANNELS);
	assign chan_sel   = te_chan_idx_t'(i_addr); // both bases are channel aligned
	assign result_sel = result_q[chan_sel];

	// ------------------------------------------------
	// configuration writes
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b) begin
			o_channel_enable <= '0;
			o_poly           <= '0;
			o_seeds          <= '{default: '0};
		end else if (wr_en) begin
			if (i_addr == TE_CHANNEL_ENABLE)
				o_channel_enable <= te_chan_mask_t'(i_wdata);
			else if (i_addr == TE_POLYNOMIAL)
				o_poly <= te_code_t'(i_wdata);
			else if (seed_hit)
				o_seeds[chan_sel] <= te_code_t'(i_wdata);
		end

	// ------------------------------------------------
	// results and ready bitmap
	// ------------------------------------------------
	always_comb begin
		dump_mask = '0;
		for (int l = 0; l < NUM_LANES; l++)
			if (i_lane_en[l])
				dump_mask[i_lane_chan[l]] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			result_q <= '{default: '0};
		else if (i_dump) begin
			for (int l = 0; l < NUM_LANES; l++)
				if (i_lane_en[l])
					result_q[i_lane_chan[l]] <= i_lane_acc[l];
		end

	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			ready_q <= '0;
		else if (wr_en && (i_addr == TE_COH_DATA_READY))
			ready_q <= te_chan_mask_t'(i_wdata); // host ack wins
		else if (i_dump)
			ready_q <= ready_q | dump_mask;
		else if (i_latch_enable)
			ready_q <= '0;

	assign o_te_ready = |ready_q;

	// ------------------------------------------------
	// read mux, same cycle as i_rd
	// ------------------------------------------------
	always_comb begin
		o_reg_rdata = '0;
		if (rd_en) begin
			if (i_addr == TE_CHANNEL_ENABLE)
				o_reg_rdata = te_word_t'(o_channel_enable);
			else if (i_addr == TE_COH_DATA_READY)
				o_reg_rdata = te_word_t'(ready_q);
			else if (i_addr == TE_POLYNOMIAL)
				o_reg_rdata = te_word_t'(o_poly);
			else if (i_addr == TE_CURR_STATE)
				o_reg_rdata = te_word_t'(i_state);
			else if (seed_hit)
				o_reg_rdata = te_word_t'(o_seeds[chan_sel]);
			else if (result_hit)
				o_reg_rdata = {{PAD_W{result_sel[ACC_W-1]}}, result_sel};
		end
	end

endmodule

//--- hw/te_sequencer.sv
// round sequencer: state machine, FIFO strobes, end of block detection
`timescale 1ns/1ps

module te_sequencer import te_core_pkg::*; (
	input  logic      clk,
	input  logic      rst_b,
	input  logic      i_start,
	input  logic      i_fifo_ready,
	input  logic      i_fifo_last_data,
	input  logic      i_fifo_data_valid,
	input  logic      i_any_enabled, // at least one channel switched on
	input  logic      i_find_done,
	input  logic      i_all_done,    // no channel left for another round
	output te_state_e o_state,
	output logic      o_latch_enable,
	output logic      o_find_start,
	output logic      o_lane_load,
	output logic      o_sample_en,
	output logic      o_dump,
	output logic      o_te_running,
	output logic      o_te_over,
	output logic      o_fifo_read,
	output logic      o_fifo_rewind,
	output logic      o_fifo_skip
);

	te_state_e                  state;
	te_state_e                  next_state;
	logic [TE_FLUSH_CYCLES-1:0] last_dly; // delayed last-sample flag
	logic                       cor_done;

	// ------------------------------------------------
	// state machine
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			state <= STAND_BY;
		else
			state <= next_state;

	always_comb begin
		next_state = state;
		case (state)
			STAND_BY:     if (i_start) next_state = IDLE;
			IDLE:         if (i_fifo_ready) next_state = START;
			START:        next_state = i_any_enabled ? FIND_CHANNEL : TE_FINISH;
			FIND_CHANNEL: if (i_find_done) next_state = LOAD_LANES;
			LOAD_LANES:   next_state = READ_FIFO;
			READ_FIFO:    next_state = CORRELATION;
			CORRELATION:  if (cor_done) next_state = DUMP;
			DUMP:         next_state = COR_FINISH;
			COR_FINISH:   next_state = i_all_done ? TE_FINISH : FIND_CHANNEL;
			TE_FINISH:    next_state = WAIT_CPU;
			WAIT_CPU:     if (i_start) next_state = IDLE;
			default:      next_state = STAND_BY;
		endcase
	end

	// let the lane pipelines drain after the last sample
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			last_dly <= '0;
		else
			last_dly <= (last_dly << 1) | TE_FLUSH_CYCLES'(i_fifo_last_data);

	assign cor_done = last_dly[TE_FLUSH_CYCLES-1];

	// ------------------------------------------------
	// strobes to finder, lanes and registers
	// ------------------------------------------------
	// latch and find pulses fire on the transition so the finder is
	// already updated in the first cycle of the new state
	assign o_latch_enable = (state == IDLE) && i_fifo_ready;
	assign o_find_start   = (next_state == FIND_CHANNEL) && (state != FIND_CHANNEL);
	assign o_lane_load    = (state == LOAD_LANES);
	assign o_sample_en    = i_fifo_data_valid && (state == CORRELATION);
	assign o_dump         = (state == DUMP);

	assign o_state        = state;
	assign o_te_over      = (state == TE_FINISH);
	assign o_te_running   = (state != STAND_BY) && (state != WAIT_CPU);

	// ------------------------------------------------
	// FIFO strobes, high during their target state
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b) begin
			o_fifo_read   <= 1'b0;
			o_fifo_rewind <= 1'b0;
			o_fifo_skip   <= 1'b0;
		end else begin
			o_fifo_read   <= (next_state == READ_FIFO);
			o_fifo_rewind <= (next_state == COR_FINISH) && !i_all_done; // replay for next round
			o_fifo_skip   <= (next_state == TE_FINISH);
		end

endmodule

//--- hw/te_channel_finder.sv
// channel finder: scans the remaining channel mask and assigns channels to lanes
`timescale 1ns/1ps

module te_channel_finder import te_regmap_pkg::*; import te_core_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst_b,
	input  logic                 i_latch_enable,
	input  logic                 i_find_start,
	input  te_chan_mask_t        i_channel_enable,
	input  te_code_t             i_seeds [TE_NUM_CHANNELS],
	output logic                 o_find_done,
	output logic                 o_all_done,
	output logic                 o_any_enabled,
	output logic [NUM_LANES-1:0] o_lane_en,
	output te_chan_idx_t         o_lane_chan [NUM_LANES],
	output te_code_t             o_lane_seed [NUM_LANES]
);

	localparam int CNT_W = $clog2(NUM_LANES + 1);

	te_chan_mask_t    remain_q;  // channels not yet served this block
	te_chan_idx_t     scan_idx;
	logic [CNT_W-1:0] lane_cnt;  // next free lane
	logic             busy;
	logic             hit;
	logic             lanes_full;
	logic             scan_end;

	assign hit        = busy && remain_q[scan_idx];
	assign lanes_full = hit && (lane_cnt == CNT_W'(NUM_LANES - 1));
	assign scan_end   = busy && (scan_idx == te_chan_idx_t'(TE_NUM_CHANNELS - 1));

	assign o_find_done   = lanes_full || scan_end;
	assign o_all_done    = ~|remain_q;
	assign o_any_enabled = |i_channel_enable;

	// one channel examined per cycle, lowest number first
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b) begin
			remain_q    <= '0;
			scan_idx    <= '0;
			lane_cnt    <= '0;
			busy        <= 1'b0;
			o_lane_en   <= '0;
			o_lane_chan <= '{default: '0};
		end else if (i_latch_enable) begin
			remain_q <= i_channel_enable;
		end else if (i_find_start) begin
			busy      <= 1'b1;
			scan_idx  <= '0;
			lane_cnt  <= '0;
			o_lane_en <= '0; // unassigned lanes stay off this round
		end else if (busy) begin
			if (hit) begin
				remain_q[scan_idx] <= 1'b0;
				lane_cnt           <= lane_cnt + 1'b1;
				for (int l = 0; l < NUM_LANES; l++) begin
					if (lane_cnt == CNT_W'(l)) begin
						o_lane_en[l]   <= 1'b1;
						o_lane_chan[l] <= scan_idx;
					end
				end
			end
			scan_idx <= scan_idx + 1'b1;
			if (o_find_done)
				busy <= 1'b0;
		end

	// seed follows the assigned channel
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++)
			o_lane_seed[l] = i_seeds[o_lane_chan[l]];
	end

endmodule

//--- hw/te_correlator_lane.sv
// correlator lane: galois lfsr code generator and signed despreading accumulator
`timescale 1ns/1ps

module te_correlator_lane import te_core_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       i_load,      // take seed, clear sum
	input  te_code_t   i_seed,
	input  te_code_t   i_poly,
	input  logic       i_sample_en,
	input  te_sample_t i_sample,
	output te_acc_t    o_acc
);

	te_code_t lfsr_q;
	te_code_t lfsr_next;
	te_acc_t  acc_q;
	te_acc_t  sample_ext;
	logic     chip;

	assign chip       = lfsr_q[0];
	assign sample_ext = te_acc_t'(i_sample); // sign extends

	// right shift, feedback folded in when the outgoing bit is set
	assign lfsr_next  = chip ? ((lfsr_q >> 1) ^ i_poly) : (lfsr_q >> 1);

	// ------------------------------------------------
	// code generator
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			lfsr_q <= '0;
		else if (i_load)
			lfsr_q <= i_seed;
		else if (i_sample_en)
			lfsr_q <= lfsr_next;

	// ------------------------------------------------
	// despreading accumulator
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_b)
		if (!rst_b)
			acc_q <= '0;
		else if (i_load)
			acc_q <= '0;
		else if (i_sample_en) begin
			if (chip)
				acc_q <= acc_q + sample_ext;
			else
				acc_q <= acc_q - sample_ext; // chip 0 maps to -1
		end

	assign o_acc = acc_q;

endmodule

//--- hw/te_core_pkg.sv
// datapath types, sequencer state encoding and correlation flush length

package te_core_pkg;

	// ------------------------------------------------
	// datapath widths
	// ------------------------------------------------
	typedef logic signed [7:0]  te_sample_t; // FIFO sample
	typedef logic signed [23:0] te_acc_t;    // correlation sum
	typedef logic [15:0]        te_code_t;   // lfsr state, seed, polynomial

	// ------------------------------------------------
	// round sequencer states
	// ------------------------------------------------
	// codes as the host sees them in CURR_STATE
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		START        = 4'd1,
		FIND_CHANNEL = 4'd2,
		LOAD_LANES   = 4'd3,
		READ_FIFO    = 4'd5,
		CORRELATION  = 4'd6,
		DUMP         = 4'd8,
		COR_FINISH   = 4'd9,
		TE_FINISH    = 4'd10,
		WAIT_CPU     = 4'd11,
		STAND_BY     = 4'd12
	} te_state_e;

	// cycles from the last sample until the lane sums are settled
	localparam int TE_FLUSH_CYCLES = 2;

endpackage

//--- hw/te_regmap_pkg.sv
// host register map: word and address types, channel types, register addresses

package te_regmap_pkg;

	// ------------------------------------------------
	// host bus types
	// ------------------------------------------------
	typedef logic [31:0] te_word_t;     // host data word
	typedef logic [5:0]  te_reg_addr_t; // register word address

	// ------------------------------------------------
	// logical channels
	// ------------------------------------------------
	localparam int TE_NUM_CHANNELS = 8;

	typedef logic [TE_NUM_CHANNELS-1:0]         te_chan_mask_t; // one bit per channel
	typedef logic [$clog2(TE_NUM_CHANNELS)-1:0] te_chan_idx_t;

	// ------------------------------------------------
	// register addresses
	// ------------------------------------------------
	localparam te_reg_addr_t TE_CHANNEL_ENABLE = 6'd0;  // rw
	localparam te_reg_addr_t TE_COH_DATA_READY = 6'd1;  // rw, ready bitmap
	localparam te_reg_addr_t TE_POLYNOMIAL     = 6'd2;  // rw, low 16 bits
	localparam te_reg_addr_t TE_CURR_STATE     = 6'd3;  // ro, state code

	// per channel blocks, channel k at base + k
	localparam te_reg_addr_t TE_SEED_BASE      = 6'd8;  // rw
	localparam te_reg_addr_t TE_RESULT_BASE    = 6'd16; // ro, sign extended

endpackage
